/* Bender.yml */
package:
  name: lsu

sources:
  # package first, then the RTL from leaf to top
  - files:
      - design/lsu_pkg.sv
      - design/lsu_load_extend.sv
      - design/lsu.sv
      - design/dmem_ram.sv
      - design/lsu_top.sv

  # testbench, reads verif/lsu_testdata.hex at run time
  - target: simulation
    files:
      - verif/lsu_tb.sv

/* design/dmem_ram.sv */
/*
 * Behavioural data RAM standing in for the real memory.
 * Word array with byte-lane writes. Each request is answered after
 * DMEM_WAIT cycles of req with a one-cycle ack; the write happens and the
 * read word appears on rdata for that ack cycle. No initial contents.
 */

`timescale 1ns/1ps
`default_nettype none

module dmem_ram
(
    input  wire  logic               clk,
    input  wire  logic               resetn,
    input  wire  lsu_pkg::dmem_req_t dmem_req,
    output lsu_pkg::word_t           rdata,
    output logic                     ack
);

    lsu_pkg::word_t     mem [0:(1 << lsu_pkg::DMEM_DEPTH_LOG2) - 1];
    lsu_pkg::byte_en_t  byte_en;
    logic [lsu_pkg::DMEM_DEPTH_LOG2-1:0] word_idx;
    logic [lsu_pkg::DMEM_WAIT_W-1:0]     wait_cnt;
    logic               done;

    assign word_idx = dmem_req.addr[lsu_pkg::DMEM_DEPTH_LOG2+1:2];   // drop byte offset

    always_comb
    begin
        case (dmem_req.size)
            lsu_pkg::SIZE_B: byte_en = 4'b0001 << dmem_req.addr[1:0];
            lsu_pkg::SIZE_H: byte_en = dmem_req.addr[1] ? 4'b1100 : 4'b0011;
            default:         byte_en = 4'b1111;
        endcase
    end

    // last wait cycle of a pending request
    assign done = dmem_req.req && !ack && (wait_cnt == lsu_pkg::DMEM_WAIT - 1);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            wait_cnt <= '0;
            ack      <= 1'b0;
        end
        else
        begin
            ack <= done;                        // one-cycle pulse
            if (dmem_req.req && !ack && !done)
                wait_cnt <= wait_cnt + 1'b1;
            else
                wait_cnt <= '0;                 // restart for the next request
        end
    end

    always_ff @(posedge clk)
    begin
        if (done)
        begin
            rdata <= mem[word_idx];
            if (dmem_req.we)
            begin
                for (int i = 0; i < 4; i++)
                begin
                    if (byte_en[i])
                        mem[word_idx][i*8 +: 8] <= dmem_req.wdata[i*8 +: 8];
                end
            end
        end
    end

    // store lanes are never empty and begin at the addressed byte
    a_store_has_lanes: assert property (@(posedge clk) disable iff (!resetn)
        dmem_req.req && dmem_req.we |->
            byte_en[dmem_req.addr[1:0]] &&
            ((byte_en & ~(4'b1111 << dmem_req.addr[1:0])) == 4'b0000));

endmodule

`default_nettype wire

/* design/lsu.sv */
/*
 * Data-side load/store unit.
 * Accepts one memory-stage operation at a time, checks its alignment,
 * places store data into the byte lanes and holds a request to the data
 * memory until ack. Loaded data is extended and captured on ack. The
 * misalignment flags are combinational on the presented op, and a sticky
 * copy keeps lsu_err high while the front end is stalled.
 */

`timescale 1ns/1ps
`default_nettype none

module lsu
(
    input  wire  logic               clk,
    input  wire  logic               resetn,
    input  wire  lsu_pkg::mem_op_t   op,            // from the memory stage
    input  wire  logic               stall,         // front end stalled
    output lsu_pkg::word_t           load_data,     // to write-back
    output logic                     busy,
    output logic                     lsu_err,
    output logic                     s_misaligned,
    output logic                     l_misaligned,
    output lsu_pkg::dmem_req_t       dmem_req,
    input  wire  lsu_pkg::word_t     rdata,
    input  wire  logic               ack
);

    logic               op_valid;
    logic               misaligned;
    logic               err_now;
    logic               err_sticky;
    lsu_pkg::word_t     store_lanes;
    lsu_pkg::word_t     load_ext;

    logic               we_q;
    logic               sign_q;
    lsu_pkg::size_t     size_q;
    lsu_pkg::word_t     addr_q;
    lsu_pkg::word_t     wdata_q;

    assign op_valid = op.we | op.rf_src;

    // halfword on an odd address, word off a 4-byte boundary
    assign misaligned = ((op.size == lsu_pkg::SIZE_H) && op.addr[0]) ||
                        ((op.size == lsu_pkg::SIZE_W) && (op.addr[1:0] != 2'b00));

    assign s_misaligned = misaligned & op.we;
    assign l_misaligned = misaligned & op.rf_src;
    assign err_now      = s_misaligned | l_misaligned;
    assign lsu_err      = err_now | err_sticky;

    // replicate narrow data so every lane carries it
    always_comb
    begin
        case (op.size)
            lsu_pkg::SIZE_B: store_lanes = {4{op.wdata[7:0]}};
            lsu_pkg::SIZE_H: store_lanes = {2{op.wdata[15:0]}};
            default:         store_lanes = op.wdata;
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            err_sticky <= 1'b0;
        else if (!stall)
            err_sticky <= 1'b0;         // any unstalled cycle clears it
        else if (err_now)
            err_sticky <= 1'b1;
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            busy <= 1'b0;
        else if (ack)
            busy <= 1'b0;
        else if (op_valid && !err_now)
            busy <= 1'b1;               // a misaligned op never starts
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            we_q <= 1'b0;
        else if (op_valid && !busy)
            we_q <= op.we;
    end

    always_ff @(posedge clk)
    begin
        if (op_valid && !busy)
        begin
            addr_q  <= op.addr;
            size_q  <= op.size;
            sign_q  <= op.sign;
            wdata_q <= store_lanes;
        end
    end

    assign dmem_req.req   = busy;       // level request until ack
    assign dmem_req.we    = we_q;
    assign dmem_req.size  = size_q;
    assign dmem_req.addr  = addr_q;
    assign dmem_req.wdata = wdata_q;

    lsu_load_extend u_load_extend
    (
        .rdata      (rdata),
        .addr_low   (addr_q[1:0]),
        .size       (size_q),
        .sign       (sign_q),
        .load_word  (load_ext)
    );

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            load_data <= '0;
        else if (ack)
            load_data <= load_ext;
    end

    // upstream holds off while a request is outstanding
    a_no_op_while_busy: assert property (@(posedge clk) disable iff (!resetn)
        busy |-> !op_valid);

    // the RAM only answers a pending request
    a_ack_only_when_busy: assert property (@(posedge clk) disable iff (!resetn)
        ack |-> busy);

endmodule

`default_nettype wire

/* design/lsu_load_extend.sv */
/*
 * Load data formatting for the write-back stage.
 * Picks the addressed byte or halfword out of the memory word and extends
 * it to a full word, by sign or by zero. Purely combinational.
 */

`timescale 1ns/1ps
`default_nettype none

module lsu_load_extend
(
    input  wire  lsu_pkg::word_t rdata,     // word returned by the RAM
    input  wire  logic [1:0]     addr_low,
    input  wire  lsu_pkg::size_t size,
    input  wire  logic           sign,
    output lsu_pkg::word_t       load_word
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    always_comb
    begin
        case (addr_low)
            2'd0:    byte_sel = rdata[7:0];
            2'd1:    byte_sel = rdata[15:8];
            2'd2:    byte_sel = rdata[23:16];
            default: byte_sel = rdata[31:24];
        endcase
        half_sel = addr_low[1] ? rdata[31:16] : rdata[15:0];    // bit 0 is zero when aligned
    end

    always_comb
    begin
        case (size)
            lsu_pkg::SIZE_B:
                load_word = {{24{byte_sel[7] & sign}}, byte_sel};
            lsu_pkg::SIZE_H:
                load_word = {{16{half_sel[15] & sign}}, half_sel};
            default:
                load_word = rdata;              // word and unknown codes
        endcase
    end

endmodule

`default_nettype wire

/* design/lsu_pkg.sv */
/*
 * Shared types and constants for the load/store unit and its data RAM.
 * Holds the word and size types, the access-size codes, the RAM wait-state
 * count and depth, and the structs for the memory-stage operation and the
 * request toward the data memory. Referenced only by scoped names.
 */

`default_nettype none

package lsu_pkg;

    typedef logic [31:0] word_t;            // data and address word
    typedef logic [1:0]  size_t;            // access size code
    typedef logic [3:0]  byte_en_t;         // one bit per byte lane

    localparam size_t SIZE_B = 2'd0;        // byte
    localparam size_t SIZE_H = 2'd1;        // halfword
    localparam size_t SIZE_W = 2'd2;        // word

    // cycles with req high before the RAM pulses ack
    localparam int unsigned DMEM_WAIT       = 2;
    localparam int unsigned DMEM_WAIT_W     = $clog2(DMEM_WAIT + 1);
    localparam int unsigned DMEM_DEPTH_LOG2 = 8;    // RAM word address bits

    // one operation handed over by the memory stage
    typedef struct packed {
        logic  we;                          // store
        logic  rf_src;                      // load into register file
        logic  sign;                        // sign-extend a load
        size_t size;
        word_t addr;
        word_t wdata;                       // raw store data
    } mem_op_t;

    // request held toward the data RAM until ack
    typedef struct packed {
        logic  req;
        logic  we;
        size_t size;
        word_t addr;
        word_t wdata;                       // already placed in its lanes
    } dmem_req_t;

endpackage

`default_nettype wire

/* design/lsu_top.sv */
/*
 * Top level of the data side.
 * Joins the load/store unit to the behavioural data RAM and exposes the
 * memory-stage operation input, the load result and the status flags.
 */

`timescale 1ns/1ps
`default_nettype none

module lsu_top
(
    input  wire  logic               clk,
    input  wire  logic               resetn,
    input  wire  lsu_pkg::mem_op_t   op,
    input  wire  logic               stall,
    output lsu_pkg::word_t           load_data,
    output logic                     busy,
    output logic                     lsu_err,
    output logic                     s_misaligned,
    output logic                     l_misaligned
);

    lsu_pkg::dmem_req_t dmem_req;       // unit to RAM
    lsu_pkg::word_t     rdata;
    logic               ack;

    lsu u_lsu
    (
        .clk            (clk),
        .resetn         (resetn),
        .op             (op),
        .stall          (stall),
        .load_data      (load_data),
        .busy           (busy),
        .lsu_err        (lsu_err),
        .s_misaligned   (s_misaligned),
        .l_misaligned   (l_misaligned),
        .dmem_req       (dmem_req),
        .rdata          (rdata),
        .ack            (ack)
    );

    dmem_ram u_dmem_ram
    (
        .clk        (clk),
        .resetn     (resetn),
        .dmem_req   (dmem_req),
        .rdata      (rdata),
        .ack        (ack)
    );

endmodule

`default_nettype wire

/* tb.f */
design/lsu_pkg.sv
design/lsu_load_extend.sv
design/lsu.sv
design/dmem_ram.sv
design/lsu_top.sv
verif/lsu_tb.sv

/* verif/lsu_tb.sv */
/*
 * Testbench for the data side top level.
 * Reads one operation per line from verif/lsu_testdata.hex, presents it for
 * one cycle, checks the misalignment flags, busy and the sticky error, and
 * checks the load result once busy falls.
 */

`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

    localparam int NUM_OPS        = 28;
    localparam int FIELDS         = 10;     // hex words per op line
    localparam int TIMEOUT_CYCLES = NUM_OPS * (lsu_pkg::DMEM_WAIT + 4) + 50;

    logic               clk;
    logic               resetn;
    lsu_pkg::mem_op_t   op;
    logic               stall;
    lsu_pkg::word_t     load_data;
    logic               busy;
    logic               lsu_err;
    logic               s_misaligned;
    logic               l_misaligned;

    lsu_pkg::word_t     vec [0:NUM_OPS*FIELDS-1];
    int                 mismatches;
    int                 other_errors;
    int                 cycles = 0;

    lsu_top dut
    (
        .clk            (clk),
        .resetn         (resetn),
        .op             (op),
        .stall          (stall),
        .load_data      (load_data),
        .busy           (busy),
        .lsu_err        (lsu_err),
        .s_misaligned   (s_misaligned),
        .l_misaligned   (l_misaligned)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;                       // 4 ns period

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES)
        begin
            $display("run timed out after %0d cycles waiting for busy to fall", cycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input lsu_pkg::word_t exp,
                              input lsu_pkg::word_t act);
        if (act !== exp)
        begin
            $display("Mismatch %s: expected %h, got %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("Mismatch %s: expected %h, got %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic run_op(input int n);
        lsu_pkg::mem_op_t   next_op;
        lsu_pkg::word_t     exp_load;
        logic               hold;
        logic               exp_s;
        logic               exp_l;
        int                 b;

        b = n * FIELDS;
        next_op.we     = vec[b][0];
        next_op.rf_src = vec[b+1][0];
        next_op.sign   = vec[b+2][0];
        next_op.size   = vec[b+3][1:0];
        next_op.addr   = vec[b+4];
        next_op.wdata  = vec[b+5];
        hold           = vec[b+6][0];
        exp_load       = vec[b+7];
        exp_s          = vec[b+8][0];
        exp_l          = vec[b+9][0];

        @(posedge clk);
        op    <= next_op;                       // present for one cycle
        stall <= hold;
        @(negedge clk);
        check_flag("s_misaligned", exp_s, s_misaligned);
        check_flag("l_misaligned", exp_l, l_misaligned);
        check_flag("lsu_err", exp_s | exp_l, lsu_err);
        @(posedge clk);
        op <= '0;
        if (exp_s || exp_l)
        begin
            // rejected op starts no request, error sticks only while stalled
            repeat (lsu_pkg::DMEM_WAIT)
            begin
                @(negedge clk);
                check_flag("busy", 1'b0, busy);
                check_flag("lsu_err", hold, lsu_err);
            end
            if (hold)
            begin
                @(posedge clk);
                stall <= 1'b0;
                @(negedge clk);
                check_flag("lsu_err", 1'b1, lsu_err);   // clears one edge later
                @(negedge clk);
                check_flag("lsu_err", 1'b0, lsu_err);
            end
        end
        else
        begin
            @(negedge clk);
            check_flag("busy", 1'b1, busy);
            while (busy)
                @(negedge clk);
            if (next_op.rf_src)
                check_word("load_data", exp_load, load_data);
        end
    endtask

    initial
    begin
        resetn       = 1'b0;
        op           = '0;
        stall        = 1'b0;
        mismatches   = 0;
        other_errors = 0;
        $readmemh("verif/lsu_testdata.hex", vec);
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        if ($isunknown(vec[NUM_OPS*FIELDS-1]))
        begin
            $display("stimulus file verif/lsu_testdata.hex is missing or too short");
            other_errors++;
        end
        else
        begin
            for (int n = 0; n < NUM_OPS; n++)
                run_op(n);
        end
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches + other_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/lsu_testdata.hex */
// we rf_src sign size addr wdata stall exp_load exp_s exp_l  (all hex, one op per line)
// exp_load is only checked for aligned loads, once busy has fallen
1 0 0 2 00000010 12345678 0 00000000 0 0
0 1 0 2 00000010 00000000 0 12345678 0 0
// byte lanes of the word at 0x20
1 0 0 2 00000020 a1b2c3d4 0 00000000 0 0
1 0 0 0 00000020 deadbe11 0 00000000 0 0
1 0 0 0 00000021 00000022 0 00000000 0 0
0 1 0 2 00000020 00000000 0 a1b22211 0 0
1 0 0 0 00000022 00000033 0 00000000 0 0
1 0 0 0 00000023 00000044 0 00000000 0 0
0 1 0 2 00000020 00000000 0 44332211 0 0
0 1 0 0 00000020 00000000 0 00000011 0 0
0 1 0 0 00000021 00000000 0 00000022 0 0
0 1 0 0 00000022 00000000 0 00000033 0 0
0 1 0 0 00000023 00000000 0 00000044 0 0
// sign and zero extension
1 0 0 2 00000030 80f17fa5 0 00000000 0 0
0 1 1 0 00000030 00000000 0 ffffffa5 0 0
0 1 0 0 00000030 00000000 0 000000a5 0 0
0 1 1 1 00000032 00000000 0 ffff80f1 0 0
0 1 0 1 00000032 00000000 0 000080f1 0 0
0 1 1 0 00000031 00000000 0 0000007f 0 0
// upper halfword store
1 0 0 1 00000012 0000beef 0 00000000 0 0
0 1 0 1 00000010 00000000 0 00005678 0 0
0 1 0 1 00000012 00000000 0 0000beef 0 0
// misaligned ops, then the untouched word
1 0 0 1 00000013 11112222 1 00000000 1 0
1 0 0 2 00000012 cafef00d 1 00000000 1 0
0 1 0 2 00000011 00000000 1 00000000 0 1
0 1 1 1 00000031 00000000 0 00000000 0 1
0 1 0 2 00000023 00000000 1 00000000 0 1
0 1 0 2 00000010 00000000 0 beef5678 0 0
